// ==== logic/objsys_consts.svh ====
`ifndef OBJSYS_CONSTS_SVH
`define OBJSYS_CONSTS_SVH

// cpu word address width, both banks included
// bit 12 picks the bank relative to obank
// bits 11:2 pick the entry
// bits 1:0 pick the word inside the entry
`define OBJ_AW 13

// objects per bank
// the graphics index is OBJ_AW-3 bits wide
`define OBJ_ENTRIES 1024

// upper byte of the attribute word
// this value ends the table
`define OBJ_END_TAG 8'hff

`endif

// ==== logic/objsys_pkg.sv ====
`include "objsys_consts.svh"

package objsys_pkg;

    // attribute word as the object engine reads it
    // the upper byte doubles as the end-of-table marker
    typedef struct packed {
        // all ones ends the table
        logic [7:0] tag;
        // flips
        logic       vflip;
        logic       hflip;
        // palette select
        logic [5:0] pal;
    } obj_attr_t;

    // one object record, four words
    // word order matches the cpu layout, X first
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        obj_attr_t   attr;
    } obj_entry_t;

    // one cpu bus write
    // 68000 style byte strobes, active low
    // dsn[1] is the upper byte, dsn[0] the lower one
    typedef struct packed {
        logic [1:0]         dsn;
        // word address, bit 0 is the 68000 A1
        logic [`OBJ_AW-1:0] addr;
        logic [15:0]        data;
    } cpu_wr_t;

endpackage

// ==== logic/dual_ram16.sv ====
module dual_ram16 #(
    parameter int aw = 10
) (
    input  logic          clk_cpu,
    // port 0
    input  logic [15:0]   data0,
    input  logic [aw-1:0] addr0,
    input  logic [1:0]    we0,
    output logic [15:0]   q0,
    // port 1
    input  logic [15:0]   data1,
    input  logic [aw-1:0] addr1,
    input  logic [1:0]    we1,
    output logic [15:0]   q1
);

    // two byte lanes per word
    // lane 1 is the upper byte
    logic [1:0][7:0] mem [0:2**aw-1];

    always_ff @(posedge clk_cpu) begin
        // registered reads
        // nonblocking, so a write on the same port
        // hands back the old word this cycle
        q0 <= mem[addr0];
        q1 <= mem[addr1];
        // port 0 byte writes
        if (we0[0]) begin
            mem[addr0][0] <= data0[7:0];
        end
        if (we0[1]) begin
            mem[addr0][1] <= data0[15:8];
        end
        // port 1 byte writes
        // same address and lane on both ports, port 1 wins
        if (we1[0]) begin
            mem[addr1][0] <= data1[7:0];
        end
        if (we1[1]) begin
            mem[addr1][1] <= data1[15:8];
        end
    end

endmodule

// ==== logic/obj_ram.sv ====
`include "objsys_consts.svh"

module obj_ram
    import objsys_pkg::*;
(
    input  logic               clk_cpu,
    input  logic               reset,
    // displayed bank select
    input  logic               obank,
    // cpu write side
    input  logic               cs,
    input  cpu_wr_t            wr,
    output logic               ok,
    // graphics read side
    input  logic [`OBJ_AW-4:0] rd_index,
    output obj_entry_t         rd_entry
);

    // row = bank bit + entry index
    localparam int row_w = `OBJ_AW - 2;

    logic [3:0]       word_sel;
    logic [1:0]       we_x;
    logic [1:0]       we_y;
    logic [1:0]       we_code;
    logic [1:0]       we_attr;
    logic [row_w-1:0] wr_row;
    logic [row_w-1:0] rd_row;
    logic [15:0]      q_x;
    logic [15:0]      q_y;
    logic [15:0]      q_code;
    logic [15:0]      q_attr;

    // word select from the two low address bits
    // 0 x, 1 y, 2 code, 3 attr
    always_comb begin
        word_sel = 4'b0000;
        if (cs) begin
            word_sel[wr.addr[1:0]] = 1'b1;
        end
    end

    // byte strobes are active low on the bus
    assign we_x    = ~wr.dsn & {2{word_sel[0]}};
    assign we_y    = ~wr.dsn & {2{word_sel[1]}};
    assign we_code = ~wr.dsn & {2{word_sel[2]}};
    assign we_attr = ~wr.dsn & {2{word_sel[3]}};

    // cpu normally lands in the hidden bank
    // address bit 12 flips it onto the shown one
    assign wr_row = {obank ^ wr.addr[`OBJ_AW-1], wr.addr[`OBJ_AW-2:2]};
    // graphics always reads the shown bank
    assign rd_row = {~obank, rd_index};

    // write ack, one cycle after select
    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            ok <= 1'b0;
        end else begin
            ok <= cs;
        end
    end

    // port 0 cpu, port 1 graphics read only
    dual_ram16 #(.aw(row_w)) u_x (
        .clk_cpu (clk_cpu),
        .data0   (wr.data),
        .addr0   (wr_row),
        .we0     (we_x),
        .q0      (),
        .data1   (16'd0),
        .addr1   (rd_row),
        .we1     (2'b00),
        .q1      (q_x)
    );

    dual_ram16 #(.aw(row_w)) u_y (
        .clk_cpu (clk_cpu),
        .data0   (wr.data),
        .addr0   (wr_row),
        .we0     (we_y),
        .q0      (),
        .data1   (16'd0),
        .addr1   (rd_row),
        .we1     (2'b00),
        .q1      (q_y)
    );

    dual_ram16 #(.aw(row_w)) u_code (
        .clk_cpu (clk_cpu),
        .data0   (wr.data),
        .addr0   (wr_row),
        .we0     (we_code),
        .q0      (),
        .data1   (16'd0),
        .addr1   (rd_row),
        .we1     (2'b00),
        .q1      (q_code)
    );

    dual_ram16 #(.aw(row_w)) u_attr (
        .clk_cpu (clk_cpu),
        .data0   (wr.data),
        .addr0   (wr_row),
        .we0     (we_attr),
        .q0      (),
        .data1   (16'd0),
        .addr1   (rd_row),
        .we1     (2'b00),
        .q1      (q_attr)
    );

    // record out, one cycle after rd_index
    assign rd_entry = {q_x, q_y, q_code, q_attr};

endmodule

// ==== logic/obj_scan.sv ====
`include "objsys_consts.svh"

module obj_scan
    import objsys_pkg::*;
(
    input  logic               clk_cpu,
    input  logic               reset,
    // one cycle pulse, e.g. vblank
    input  logic               start,
    // table read port
    output logic [`OBJ_AW-4:0] rd_index,
    input  obj_entry_t         rd_entry,
    // record stream
    output obj_entry_t         obj,
    output logic               obj_valid,
    output logic               done,
    output logic               busy
);

    localparam int iw = `OBJ_AW - 3;
    localparam logic [iw-1:0] last_idx = iw'(`OBJ_ENTRIES - 1);

    // next entry to read
    // sits at 0 while idle, so entry 0 is read on the start edge
    logic [iw-1:0] idx;
    // idx holds a live read address this cycle
    logic          rd_act;
    // ram output holds a live record
    logic          pend;
    // and that record is the last entry
    logic          pend_last;
    // last record sent, done goes out next
    logic          tail;
    logic          issue;
    logic          is_end;

    // a read is real when a scan starts or one is running
    // start is dropped while busy
    assign issue = (start && !busy) || rd_act;

    assign is_end = (rd_entry.attr.tag == `OBJ_END_TAG);

    assign rd_index = idx;

    always_ff @(posedge clk_cpu) begin
        if (reset) begin
            idx       <= '0;
            rd_act    <= 1'b0;
            pend      <= 1'b0;
            pend_last <= 1'b0;
            tail      <= 1'b0;
            busy      <= 1'b0;
            obj_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            obj_valid <= 1'b0;
            done      <= 1'b0;
            tail      <= 1'b0;
            // ram latency stage
            pend      <= issue;
            pend_last <= issue && (idx == last_idx);
            // wraps back to 0 after the last entry
            if (issue) begin
                idx <= idx + 1'b1;
            end
            rd_act <= issue && (idx != last_idx);
            if (start && !busy) begin
                busy <= 1'b1;
            end
            // result check
            if (pend) begin
                if (is_end) begin
                    // end marker, no valid for it
                    // kill reads still in flight
                    done      <= 1'b1;
                    busy      <= 1'b0;
                    rd_act    <= 1'b0;
                    pend      <= 1'b0;
                    pend_last <= 1'b0;
                    idx       <= '0;
                end else begin
                    obj_valid <= 1'b1;
                    tail      <= pend_last;
                end
            end
            // no marker in the whole bank
            if (tail) begin
                done <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

    // record payload
    always_ff @(posedge clk_cpu) begin
        if (pend) begin
            obj <= rd_entry;
        end
    end

endmodule

// ==== logic/objsys_top.sv ====
`include "objsys_consts.svh"

module objsys_top
    import objsys_pkg::*;
(
    input  logic       clk_cpu,
    input  logic       reset,
    // displayed bank
    input  logic       obank,
    // cpu bus
    input  logic       cs,
    input  cpu_wr_t    wr,
    output logic       ok,
    // scan control and record stream
    input  logic       start,
    output obj_entry_t obj,
    output logic       obj_valid,
    output logic       done,
    output logic       busy
);

    // scanner to table
    logic [`OBJ_AW-4:0] rd_index;
    obj_entry_t         rd_entry;

    // double buffered object table
    obj_ram u_ram (
        .clk_cpu  (clk_cpu),
        .reset    (reset),
        .obank    (obank),
        .cs       (cs),
        .wr       (wr),
        .ok       (ok),
        .rd_index (rd_index),
        .rd_entry (rd_entry)
    );

    // walks the shown bank
    obj_scan u_scan (
        .clk_cpu   (clk_cpu),
        .reset     (reset),
        .start     (start),
        .rd_index  (rd_index),
        .rd_entry  (rd_entry),
        .obj       (obj),
        .obj_valid (obj_valid),
        .done      (done),
        .busy      (busy)
    );

endmodule

// ==== tests/objsys_asserts.sv ====
`include "objsys_consts.svh"

module objsys_asserts
    import objsys_pkg::*;
(
    input logic       clk_cpu,
    input logic       reset,
    input logic       obank,
    input logic       cs,
    input logic       ok,
    input obj_entry_t obj,
    input logic       obj_valid,
    input logic       done,
    input logic       busy
);

    // running count of failed checks
    int fails = 0;

    // ack is cs one cycle late
    ack_delay: assert property (@(posedge clk_cpu) disable iff (reset)
        ok == $past(cs))
        else begin
            fails++;
            $error("ok does not follow cs by one cycle");
        end

    // the end record is swallowed, never sent
    valid_not_done: assert property (@(posedge clk_cpu) disable iff (reset)
        !(obj_valid && done))
        else begin
            fails++;
            $error("obj_valid and done high together");
        end

    // busy drops with done
    done_idle: assert property (@(posedge clk_cpu) disable iff (reset)
        done |-> !busy)
        else begin
            fails++;
            $error("busy still high at done");
        end

    // bank swap only between scans
    bank_hold: assert property (@(posedge clk_cpu) disable iff (reset)
        busy |-> $stable(obank))
        else begin
            fails++;
            $error("obank changed during a scan");
        end

    // records out never carry the marker
    no_tag_out: assert property (@(posedge clk_cpu) disable iff (reset)
        obj_valid |-> (obj.attr.tag != `OBJ_END_TAG))
        else begin
            fails++;
            $error("end marker sent as a record");
        end

endmodule

bind objsys_top objsys_asserts u_asserts (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .obank     (obank),
    .cs        (cs),
    .ok        (ok),
    .obj       (obj),
    .obj_valid (obj_valid),
    .done      (done),
    .busy      (busy)
);

// ==== tests/objsys_tb.sv ====
`include "objsys_consts.svh"

module objsys_tb
    import objsys_pkg::*;
();

    typedef enum logic [1:0] {op_write, op_bank, op_scan} op_t;

    // one table row
    typedef struct {
        string   name;
        op_t     op;
        cpu_wr_t wr;
        logic    bank;
        int      exp_count;
    } step_t;

    logic       clk_cpu;
    logic       reset;
    logic       obank;
    logic       cs;
    cpu_wr_t    wr;
    logic       ok;
    logic       start;
    obj_entry_t obj;
    logic       obj_valid;
    logic       done;
    logic       busy;

    step_t      steps[$];
    // expected table indexed by physical bank and entry
    obj_entry_t model [0:1][0:`OBJ_ENTRIES-1];
    integer     seed = 18;
    logic       built = 1'b0;
    string      cur_name = "reset";
    int         entry_errs = 0;
    int         bit_errs = 0;
    int         count_errs = 0;
    int         other_errs = 0;
    int         assert_errs;

    objsys_top dut0 (
        .clk_cpu   (clk_cpu),
        .reset     (reset),
        .obank     (obank),
        .cs        (cs),
        .wr        (wr),
        .ok        (ok),
        .start     (start),
        .obj       (obj),
        .obj_valid (obj_valid),
        .done      (done),
        .busy      (busy)
    );

    always #5 clk_cpu = ~clk_cpu;

    task automatic check_entry(string what, obj_entry_t exp, obj_entry_t act);
        if (act !== exp) begin
            entry_errs++;
            $display("[ERROR] %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("[ERROR] %s %s expected %b actual %b", cur_name, what, exp, act);
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            count_errs++;
            $display("[ERROR] %s %s expected %0d actual %0d", cur_name, what, exp, act);
        end
    endtask

    // one clock with inputs changing 1 unit later
    // ok must mirror the cs of the edge just taken
    task automatic tick();
        logic cs_q;
        logic rst_q;
        cs_q = cs;
        rst_q = reset;
        @(posedge clk_cpu);
        #1;
        if (!rst_q) begin
            check_bit("ok", cs_q, ok);
        end
    endtask

    function automatic obj_entry_t random_entry();
        obj_entry_t e;
        e.x = 16'($random(seed));
        e.y = 16'($random(seed));
        e.code = 16'($random(seed));
        e.attr = obj_attr_t'(16'($random(seed)));
        // never the end marker
        e.attr.tag[7] = 1'b0;
        return e;
    endfunction

    task automatic push_step(string name, op_t op, cpu_wr_t w, logic bank, int cnt);
        step_t s;
        s.name = name;
        s.op = op;
        s.wr = w;
        s.bank = bank;
        s.exp_count = cnt;
        steps.push_back(s);
    endtask

    // four full-word writes starting with X
    task automatic store_entry(string name, logic a12, int idx, obj_entry_t e);
        cpu_wr_t     w;
        logic [63:0] flat;
        flat = e;
        for (int k = 0; k < 4; k++) begin
            w.dsn = 2'b00;
            w.addr = {a12, idx[`OBJ_AW-4:0], 2'(k)};
            w.data = flat[48 - 16 * k +: 16];
            push_step(name, op_write, w, 1'b0, 0);
        end
    endtask

    task automatic lane_write(string name, logic [1:0] dsn, int idx, int word);
        cpu_wr_t w;
        w.dsn = dsn;
        w.addr = {1'b0, idx[`OBJ_AW-4:0], 2'(word)};
        w.data = 16'($random(seed));
        push_step(name, op_write, w, 1'b0, 0);
    endtask

    // bank and byte rule applied to the expected table
    task automatic model_write(cpu_wr_t w);
        logic        b;
        int          i;
        int          lo;
        logic [63:0] flat;
        logic [15:0] word;
        b = obank ^ w.addr[`OBJ_AW-1];
        i = int'(w.addr[`OBJ_AW-2:2]);
        lo = 48 - 16 * int'(w.addr[1:0]);
        flat = model[b][i];
        word = flat[lo +: 16];
        // strobes active low
        if (!w.dsn[1]) begin
            word[15:8] = w.data[15:8];
        end
        if (!w.dsn[0]) begin
            word[7:0] = w.data[7:0];
        end
        flat[lo +: 16] = word;
        model[b][i] = flat;
    endtask

    task automatic build_table();
        obj_entry_t tag_e;
        cpu_wr_t    none;
        none = '0;
        // with obank 0 the hidden bank is 0 and the shown bank is 1
        for (int i = 0; i < 12; i++) begin
            store_entry("hidden_fill", 1'b0, i, random_entry());
        end
        tag_e = random_entry();
        tag_e.attr.tag = `OBJ_END_TAG;
        store_entry("hidden_end", 1'b0, 12, tag_e);
        // upper only, lower only, attr lower only
        lane_write("lane_upper", 2'b01, 3, 2);
        lane_write("lane_lower", 2'b10, 5, 0);
        lane_write("lane_attr", 2'b10, 7, 3);
        // bit 12 set lands on the shown bank
        store_entry("shown_end", 1'b1, 0, tag_e);
        push_step("hidden_not_shown", op_scan, none, 1'b0, 0);
        push_step("swap_to_1", op_bank, none, 1'b1, 0);
        push_step("swapped_table", op_scan, none, 1'b0, 12);
        // with obank 1 direct writes go into the shown bank
        store_entry("direct_entry", 1'b1, 12, random_entry());
        store_entry("direct_end", 1'b1, 13, tag_e);
        push_step("direct_writes", op_scan, none, 1'b0, 13);
        // whole hidden bank with no marker anywhere
        for (int i = 0; i < `OBJ_ENTRIES; i++) begin
            store_entry("full_fill", 1'b0, i, random_entry());
        end
        push_step("swap_to_0", op_bank, none, 1'b0, 0);
        push_step("full_table", op_scan, none, 1'b0, `OBJ_ENTRIES);
    endtask

    task automatic run_scan(int exp_cnt);
        logic disp;
        int   n;
        int   t;
        disp = ~obank;
        n = 0;
        start = 1'b1;
        tick();
        start = 1'b0;
        t = 1;
        check_bit("busy after start", 1'b1, busy);
        while (!done && t < `OBJ_ENTRIES + 4) begin
            tick();
            t++;
            start = 1'b0;
            if (obj_valid) begin
                // entry k shows up k+2 cycles after start
                check_count("valid cycle", n + 2, t);
                if (n < `OBJ_ENTRIES) begin
                    check_entry("record", model[disp][n], obj);
                end
                n++;
            end
            // extra pulse while busy should be dropped
            if (t == 3 && busy) begin
                start = 1'b1;
            end
        end
        if (!done) begin
            other_errs++;
            $display("scan %s never reported done", cur_name);
        end else begin
            check_count("done cycle", n + 2, t);
            check_bit("busy at done", 1'b0, busy);
        end
        check_count("record count", exp_cnt, n);
        // stray records or a restarted scan would show here
        repeat (3) begin
            tick();
            check_bit("idle valid", 1'b0, obj_valid);
            check_bit("idle busy", 1'b0, busy);
        end
    endtask

    // watchdog sized from the table
    initial begin
        wait (built);
        #((steps.size() + 2 * `OBJ_ENTRIES + 100) * 10);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk_cpu = 1'b0;
        reset = 1'b1;
        obank = 1'b0;
        cs = 1'b0;
        wr = '0;
        start = 1'b0;
        build_table();
        built = 1'b1;
        repeat (8) tick();
        reset = 1'b0;
        tick();
        check_bit("ok", 1'b0, ok);
        check_bit("obj_valid", 1'b0, obj_valid);
        check_bit("done", 1'b0, done);
        check_bit("busy", 1'b0, busy);
        for (int i = 0; i < steps.size(); i++) begin
            cur_name = steps[i].name;
            case (steps[i].op)
                op_write: begin
                    cs = 1'b1;
                    wr = steps[i].wr;
                    model_write(steps[i].wr);
                    tick();
                    cs = 1'b0;
                end
                op_bank: begin
                    obank = steps[i].bank;
                    tick();
                end
                op_scan: begin
                    run_scan(steps[i].exp_count);
                end
                default: begin
                    other_errs++;
                    $display("step %s has an unknown operation", cur_name);
                end
            endcase
        end
        tick();
        assert_errs = dut0.u_asserts.fails;
        $display("errors: entry %0d, bit %0d, count %0d, other %0d, assert %0d",
                 entry_errs, bit_errs, count_errs, other_errs, assert_errs);
        if (entry_errs + bit_errs + count_errs + other_errs + assert_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== objsys.f ====
+incdir+logic
logic/objsys_pkg.sv
logic/dual_ram16.sv
logic/obj_ram.sv
logic/obj_scan.sv
logic/objsys_top.sv
tests/objsys_asserts.sv
tests/objsys_tb.sv

// ==== Makefile ====
TOP      ?= objsys_tb
LOG      ?= sim.log
FLIST    ?= objsys.f
OBJDIR   ?= obj_dir
VFLAGS   ?= --assert
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	verilator --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
